// ==== filelist.f ====
+incdir+hdl
hdl/debug_csr_pkg.sv
hdl/csr_bus_pkg.sv
hdl/csr_req_issuer.sv
hdl/csr_req_fifo.sv
hdl/debug_csr_file.sv
hdl/debug_csr_top.sv
dv/debug_csr_tb.sv

// ==== Bender.yml ====
package:
  name: debug_csr

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/debug_csr_pkg.sv
      - hdl/csr_bus_pkg.sv
      - hdl/csr_req_issuer.sv
      - hdl/csr_req_fifo.sv
      - hdl/debug_csr_file.sv
      - hdl/debug_csr_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/debug_csr_tb.sv

// ==== dv/debug_csr_tb.sv ====
`timescale 1ns/1ps

`include "debug_consts.svh"

module debug_csr_tb;

    localparam int TIMEOUT = 200;
    localparam logic [11:0] DCSR = debug_csr_pkg::CSR_DCSR;
    localparam logic [11:0] DPC  = debug_csr_pkg::CSR_DPC;
    localparam logic [11:0] DS0  = debug_csr_pkg::CSR_DSCRATCH0;
    localparam logic [11:0] DS1  = debug_csr_pkg::CSR_DSCRATCH1;
    localparam logic [11:0] BAD  = 12'h7b5;

    // csr access or debug entry, with the expected result
    typedef struct packed {
        logic                       is_entry;
        logic                       wr;
        logic [11:0]                addr;
        logic [`DBG_XLEN-1:0]       wdata;
        csr_bus_pkg::dbg_entry_t    entry;
        logic [`DBG_XLEN-1:0]       exp_rdata;
        logic                       exp_err;
    } row_t;

    logic                       CLK;
    logic                       nRST;
    logic                       req_valid;
    csr_bus_pkg::csr_req_t      req;
    logic                       req_ready;
    logic                       rsp_valid;
    csr_bus_pkg::csr_rsp_t      rsp;
    logic                       rsp_ready;
    logic                       dbg_entry_valid;
    csr_bus_pkg::dbg_entry_t    dbg_entry;
    logic [`DBG_XLEN-1:0]       current_dpc;

    row_t   rows[$];
    int     rsp_count;
    int     blocked;
    int     seed;

    debug_csr_top u_dut (
        .CLK             (CLK),
        .nRST            (nRST),
        .req_valid       (req_valid),
        .req             (req),
        .req_ready       (req_ready),
        .rsp_valid       (rsp_valid),
        .rsp             (rsp),
        .rsp_ready       (rsp_ready),
        .dbg_entry_valid (dbg_entry_valid),
        .dbg_entry       (dbg_entry),
        .current_dpc     (current_dpc)
    );

    always #2 CLK = ~CLK;

    // dcsr word from its fields, xdebugver never changes
    function automatic logic [31:0] dcsr_image(logic em, logic es, logic eu, logic [2:0] cause,
                                                logic step, logic [1:0] prv);
        debug_csr_pkg::dcsr_word_u w;
        w.raw              = '0;
        w.fields.xdebugver = 4'(`DBG_XDEBUGVER);
        w.fields.ebreakm   = em;
        w.fields.ebreaks   = es;
        w.fields.ebreaku   = eu;
        w.fields.cause     = cause;
        w.fields.step      = step;
        w.fields.prv       = prv;
        return w.raw;
    endfunction

    function automatic void add_access(logic wr, logic [11:0] addr, logic [31:0] wdata,
                                       logic [31:0] exp_rdata, logic exp_err);
        row_t r;
        r = '{1'b0, wr, addr, wdata, 39'b0, exp_rdata, exp_err};
        rows.push_back(r);
    endfunction

    // dpc must follow the injected pc
    function automatic void add_entry(logic irq, logic [3:0] code, logic [31:0] pc,
                                      logic [1:0] prv);
        row_t r;
        r = '{1'b1, 1'b0, 12'h0, 32'h0, {irq, code, pc, prv}, pc, 1'b0};
        rows.push_back(r);
    endfunction

    task automatic check_value(input logic [32:0] actual, input logic [32:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out at %0t ns while waiting for %s", $time, what);
        $display("Regression failed");
        $fatal(1, "stopped on a timeout");
    endtask

    function automatic void build_table();
        logic [31:0] d_rst;
        logic [31:0] d_ones;
        logic [31:0] d_m;
        logic [31:0] d_bp;
        logic [31:0] d_halt;
        logic [31:0] d_other;
        logic [31:0] d_burst;
        d_rst   = dcsr_image(0, 0, 0, 3'd0, 0, 2'd3);
        d_ones  = dcsr_image(1, 1, 1, 3'd0, 1, 2'd3);
        d_m     = dcsr_image(1, 0, 0, 3'd0, 0, 2'd0);
        d_bp    = dcsr_image(1, 0, 0, 3'd1, 0, 2'd1);
        d_halt  = dcsr_image(1, 0, 0, 3'd3, 0, 2'd0);
        d_other = dcsr_image(1, 0, 0, 3'd3, 0, 2'd3);
        d_burst = dcsr_image(0, 0, 1, 3'd3, 1, 2'd3);
        // reset values
        add_access(0, DCSR, 0, d_rst, 0);
        add_access(0, DPC, 0, 0, 0);
        add_access(0, DS0, 0, 0, 0);
        add_access(0, DS1, 0, 0, 0);
        // writes answer with the old value
        add_access(1, DPC, 32'h8000_1000, 0, 0);
        add_access(1, DPC, 32'h8000_2000, 32'h8000_1000, 0);
        add_access(0, DPC, 0, 32'h8000_2000, 0);
        add_access(1, DS0, 32'hdead_beef, 0, 0);
        add_access(1, DS1, 32'h1234_5678, 0, 0);
        add_access(0, DS0, 0, 32'hdead_beef, 0);
        add_access(0, DS1, 0, 32'h1234_5678, 0);
        // warl on dcsr, prv of 2 is refused
        add_access(1, DCSR, 32'hffff_ffff, d_rst, 0);
        add_access(0, DCSR, 0, d_ones, 0);
        add_access(1, DCSR, 32'h0000_0002, d_ones, 0);
        add_access(0, DCSR, 0, d_rst, 0);
        add_access(1, DCSR, 32'h0000_8000, d_rst, 0);
        add_access(0, DCSR, 0, d_m, 0);
        // breakpoint, debug interrupt, then an unrelated trap
        add_entry(1'b0, debug_csr_pkg::BREAKPOINT, 32'h0040_0100, 2'd1);
        add_access(0, DPC, 0, 32'h0040_0100, 0);
        add_access(0, DCSR, 0, d_bp, 0);
        add_entry(1'b1, debug_csr_pkg::DEBUG_INT_M, 32'h0040_0200, 2'd0);
        add_access(0, DCSR, 0, d_halt, 0);
        add_entry(1'b0, 4'd2, 32'h0040_0300, 2'd3);
        add_access(0, DPC, 0, 32'h0040_0300, 0);
        add_access(0, DCSR, 0, d_other, 0);
        // unknown address leaves everything alone
        add_access(1, BAD, 32'hffff_ffff, 0, 1);
        add_access(0, BAD, 0, 0, 1);
        add_access(0, DS0, 0, 32'hdead_beef, 0);
        add_access(0, DS1, 0, 32'h1234_5678, 0);
        add_access(0, DCSR, 0, d_other, 0);
        // burst deeper than the queue
        add_access(1, DS0, 32'h1111_1111, 32'hdead_beef, 0);
        add_access(1, DS1, 32'h2222_2222, 32'h1234_5678, 0);
        add_access(0, DS0, 0, 32'h1111_1111, 0);
        add_access(1, DS0, 32'h3333_3333, 32'h1111_1111, 0);
        add_access(1, DPC, 32'h4444_4444, 32'h0040_0300, 0);
        add_access(0, DS1, 0, 32'h2222_2222, 0);
        add_access(1, DCSR, 32'h0000_1006, d_other, 0);
        add_access(0, DCSR, 0, d_burst, 0);
        add_access(0, DS0, 0, 32'h3333_3333, 0);
        add_access(0, DPC, 0, 32'h4444_4444, 0);
    endfunction

    task automatic drive_rows();
        int issued;
        int waited;
        issued = 0;
        foreach (rows[i]) begin
            waited = 0;
            if (rows[i].is_entry) begin
                // entry only once every earlier access has answered
                req_valid = 1'b0;
                while (rsp_count != issued) begin
                    @(posedge CLK);
                    #1;
                    waited++;
                    if (waited > TIMEOUT) begin
                        report_timeout("the responses ahead of a debug entry");
                    end
                end
                dbg_entry_valid = 1'b1;
                dbg_entry       = rows[i].entry;
                @(posedge CLK);
                #1;
                dbg_entry_valid = 1'b0;
                dbg_entry       = '0;
                check_value(current_dpc, rows[i].exp_rdata, $sformatf("current_dpc, row %0d", i));
            end else begin
                req_valid = 1'b1;
                req       = '{rows[i].wr, rows[i].addr, rows[i].wdata};
                while (!req_ready) begin
                    @(posedge CLK);
                    #1;
                    waited++;
                    if (waited > TIMEOUT) begin
                        report_timeout("req_ready");
                    end
                end
                // a wait past the staging cycle means the credits ran out
                if (waited > 1) begin
                    blocked++;
                end
                @(posedge CLK);
                #1;
                issued++;
            end
        end
        req_valid = 1'b0;
    endtask

    task automatic collect_responses();
        int waited;
        int stall;
        foreach (rows[i]) begin
            if (!rows[i].is_entry) begin
                // hold the response off for a random number of cycles
                stall = ($urandom % 2 == 0) ? int'($urandom % 16) : 0;
                repeat (stall) begin
                    rsp_ready = 1'b0;
                    @(posedge CLK);
                    #1;
                end
                rsp_ready = 1'b1;
                waited    = 0;
                while (!rsp_valid) begin
                    @(posedge CLK);
                    #1;
                    waited++;
                    if (waited > TIMEOUT) begin
                        report_timeout("rsp_valid");
                    end
                end
                check_value(rsp.err, rows[i].exp_err, $sformatf("rsp.err, row %0d", i));
                check_value(rsp.rdata, rows[i].exp_rdata, $sformatf("rsp.rdata, row %0d", i));
                @(posedge CLK);
                #1;
                rsp_count++;
            end
        end
    endtask

    initial begin
        seed = 68;
        void'($urandom(seed));
        CLK             = 1'b0;
        nRST            = 1'b0;
        req_valid       = 1'b0;
        req             = '0;
        rsp_ready       = 1'b0;
        dbg_entry_valid = 1'b0;
        dbg_entry       = '0;
        rsp_count       = 0;
        blocked         = 0;
        build_table();
        repeat (8) @(posedge CLK);
        #1;
        nRST = 1'b1;
        check_value(req_ready, 1'b1, "req_ready after reset");
        check_value(rsp_valid, 1'b0, "rsp_valid after reset");
        fork
            drive_rows();
            collect_responses();
        join
        // no response beyond the last request
        rsp_ready = 1'b1;
        repeat (10) begin
            @(posedge CLK);
            #1;
            check_value(rsp_valid, 1'b0, "rsp_valid after the last response");
        end
        check_value(blocked != 0, 1'b1, "req_ready held low by exhausted credits");
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== hdl/debug_csr_top.sv ====
`timescale 1ns/1ps

module debug_csr_top (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        req_valid,
    input  csr_bus_pkg::csr_req_t       req,
    output logic                        req_ready,
    output logic                        rsp_valid,
    output csr_bus_pkg::csr_rsp_t       rsp,
    input  logic                        rsp_ready,
    input  logic                        dbg_entry_valid,
    input  csr_bus_pkg::dbg_entry_t     dbg_entry,
    output logic [31:0]                 current_dpc
);

    // issuer to fifo
    logic                   push;
    csr_bus_pkg::csr_req_t  push_data;
    logic                   credit_return;

    // fifo to csr file
    logic                   not_empty;
    csr_bus_pkg::csr_req_t  head;
    logic                   pop;

    csr_req_issuer u_issuer (
        .CLK           (CLK),
        .nRST          (nRST),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .push          (push),
        .push_data     (push_data),
        .credit_return (credit_return)
    );

    csr_req_fifo u_fifo (
        .CLK           (CLK),
        .nRST          (nRST),
        .push          (push),
        .push_data     (push_data),
        .pop           (pop),
        .not_empty     (not_empty),
        .head          (head),
        .credit_return (credit_return)
    );

    debug_csr_file u_csr_file (
        .CLK             (CLK),
        .nRST            (nRST),
        .not_empty       (not_empty),
        .head            (head),
        .pop             (pop),
        .rsp_valid       (rsp_valid),
        .rsp             (rsp),
        .rsp_ready       (rsp_ready),
        .dbg_entry_valid (dbg_entry_valid),
        .dbg_entry       (dbg_entry),
        .current_dpc     (current_dpc)
    );

endmodule

// ==== hdl/debug_csr_file.sv ====
`timescale 1ns/1ps

`include "debug_consts.svh"

module debug_csr_file (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        not_empty,
    input  csr_bus_pkg::csr_req_t       head,
    output logic                        pop,
    output logic                        rsp_valid,
    output csr_bus_pkg::csr_rsp_t       rsp,
    input  logic                        rsp_ready,
    input  logic                        dbg_entry_valid,
    input  csr_bus_pkg::dbg_entry_t     dbg_entry,
    output logic [`DBG_XLEN-1:0]        current_dpc
);

    // xdebugver fixed, prv starts in machine mode
    localparam logic [`DBG_XLEN-1:0] DCSR_RESET =
        {4'(`DBG_XDEBUGVER), 26'b0, debug_csr_pkg::PRV_M};

    debug_csr_pkg::dcsr_word_u  dcsr_q;
    debug_csr_pkg::dcsr_word_u  dcsr_d;
    debug_csr_pkg::dcsr_word_u  wr_dcsr;
    logic [`DBG_XLEN-1:0]       dpc_q;
    logic [`DBG_XLEN-1:0]       dpc_d;
    logic [`DBG_XLEN-1:0]       dscratch0_q;
    logic [`DBG_XLEN-1:0]       dscratch0_d;
    logic [`DBG_XLEN-1:0]       dscratch1_q;
    logic [`DBG_XLEN-1:0]       dscratch1_d;
    logic [`DBG_XLEN-1:0]       rd_data;
    logic                       addr_err;
    debug_csr_pkg::dbg_cause_e  entry_cause;
    csr_bus_pkg::csr_rsp_t      rsp_q;

    // a free or draining response slot lets the next request through
    assign pop = not_empty && (!rsp_valid || rsp_ready);

    assign rsp         = rsp_q;
    assign current_dpc = dpc_q;
    assign wr_dcsr.raw = head.wdata;

    // read mux, old value on writes as well
    always_comb begin
        rd_data  = '0;
        addr_err = 1'b0;
        case (head.addr)
            debug_csr_pkg::CSR_DCSR:      rd_data = dcsr_q.raw;
            debug_csr_pkg::CSR_DPC:       rd_data = dpc_q;
            debug_csr_pkg::CSR_DSCRATCH0: rd_data = dscratch0_q;
            debug_csr_pkg::CSR_DSCRATCH1: rd_data = dscratch1_q;
            default:                      addr_err = 1'b1;
        endcase
    end

    // trap kind to dcsr.cause
    always_comb begin
        entry_cause = debug_csr_pkg::CAUSE_NONE;
        if (dbg_entry.irq && dbg_entry.code == debug_csr_pkg::DEBUG_INT_M) begin
            entry_cause = debug_csr_pkg::CAUSE_HALTREQ;
        end else if (!dbg_entry.irq && dbg_entry.code == debug_csr_pkg::BREAKPOINT) begin
            entry_cause = debug_csr_pkg::CAUSE_EBREAK;
        end
    end

    always_comb begin
        dcsr_d      = dcsr_q;
        dpc_d       = dpc_q;
        dscratch0_d = dscratch0_q;
        dscratch1_d = dscratch1_q;

        if (pop && head.wr) begin
            case (head.addr)
                debug_csr_pkg::CSR_DCSR: begin
                    // warl, only these fields take the written value
                    dcsr_d.fields.ebreakm = wr_dcsr.fields.ebreakm;
                    dcsr_d.fields.ebreaks = wr_dcsr.fields.ebreaks;
                    dcsr_d.fields.ebreaku = wr_dcsr.fields.ebreaku;
                    dcsr_d.fields.step    = wr_dcsr.fields.step;
                    if (wr_dcsr.fields.prv != debug_csr_pkg::PRV_RSVD) begin
                        dcsr_d.fields.prv = wr_dcsr.fields.prv;
                    end
                end
                debug_csr_pkg::CSR_DPC:       dpc_d       = head.wdata;
                debug_csr_pkg::CSR_DSCRATCH0: dscratch0_d = head.wdata;
                debug_csr_pkg::CSR_DSCRATCH1: dscratch1_d = head.wdata;
                default: ;
            endcase
        end

        // debug entry overrides a same-cycle csr write
        if (dbg_entry_valid) begin
            dpc_d             = dbg_entry.pc;
            dcsr_d.fields.prv = dbg_entry.prv;
            if (entry_cause != debug_csr_pkg::CAUSE_NONE) begin
                dcsr_d.fields.cause = entry_cause;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dcsr_q.raw  <= DCSR_RESET;
            dpc_q       <= '0;
            dscratch0_q <= '0;
            dscratch1_q <= '0;
            rsp_valid   <= 1'b0;
        end else begin
            dcsr_q      <= dcsr_d;
            dpc_q       <= dpc_d;
            dscratch0_q <= dscratch0_d;
            dscratch1_q <= dscratch1_d;
            if (pop) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    // response payload
    always_ff @(posedge CLK) begin
        if (pop) begin
            rsp_q.err   <= addr_err;
            rsp_q.rdata <= rd_data;
        end
    end

    a_rsp_stable: assert property (
        @(posedge CLK) disable iff (!nRST)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    ) else $error("response changed while stalled");

endmodule

// ==== hdl/csr_req_fifo.sv ====
`timescale 1ns/1ps

`include "debug_consts.svh"

module csr_req_fifo (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    push,
    input  csr_bus_pkg::csr_req_t   push_data,
    input  logic                    pop,
    output logic                    not_empty,
    output csr_bus_pkg::csr_req_t   head,
    output logic                    credit_return
);

    localparam int AW = $clog2(`DBG_FIFO_DEPTH);
    localparam logic [AW-1:0] PTR_LAST = AW'(`DBG_FIFO_DEPTH - 1);
    localparam logic [`DBG_CREDIT_W-1:0] COUNT_FULL = `DBG_CREDIT_W'(`DBG_FIFO_DEPTH);

    csr_bus_pkg::csr_req_t      mem [`DBG_FIFO_DEPTH];
    logic [AW-1:0]              wr_ptr;
    logic [AW-1:0]              rd_ptr;
    logic [`DBG_CREDIT_W-1:0]   count;

    assign not_empty     = (count != '0);
    assign head          = mem[rd_ptr];
    // each freed slot goes straight back to the issuer
    assign credit_return = pop;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // credit protocol upstream keeps the queue from overflowing
    a_no_overflow: assert property (
        @(posedge CLK) disable iff (!nRST)
        push |-> (count != COUNT_FULL)
    ) else $error("request fifo pushed while full");

    a_no_underflow: assert property (
        @(posedge CLK) disable iff (!nRST)
        pop |-> (count != '0)
    ) else $error("request fifo popped while empty");

endmodule

// ==== hdl/csr_req_issuer.sv ====
`timescale 1ns/1ps

`include "debug_consts.svh"

module csr_req_issuer (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    req_valid,
    input  csr_bus_pkg::csr_req_t   req,
    output logic                    req_ready,
    output logic                    push,
    output csr_bus_pkg::csr_req_t   push_data,
    input  logic                    credit_return
);

    localparam logic [`DBG_CREDIT_W-1:0] CREDITS_FULL = `DBG_CREDIT_W'(`DBG_FIFO_DEPTH);

    logic [`DBG_CREDIT_W-1:0]   credits;
    logic [`DBG_CREDIT_W-1:0]   credits_next;
    logic                       stage_valid;
    csr_bus_pkg::csr_req_t      stage_q;
    logic                       accept;

    // only take a request we are sure to push next cycle
    assign req_ready = (credits != '0) && !stage_valid;
    assign accept    = req_valid && req_ready;

    assign push      = stage_valid;
    assign push_data = stage_q;

    always_comb begin
        credits_next = credits;
        case ({push, credit_return})
            2'b10: credits_next = credits - 1'b1;
            2'b01: credits_next = credits + 1'b1;
            default: credits_next = credits;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            credits     <= CREDITS_FULL;
            stage_valid <= 1'b0;
        end else begin
            credits     <= credits_next;
            // staged entry always leaves on the following cycle
            stage_valid <= accept;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            stage_q <= req;
        end
    end

    // returns only come back for entries that were pushed
    a_credit_bound: assert property (
        @(posedge CLK) disable iff (!nRST)
        credits <= CREDITS_FULL
    ) else $error("issuer credit count above fifo depth");

    a_push_has_credit: assert property (
        @(posedge CLK) disable iff (!nRST)
        push |-> (credits != '0)
    ) else $error("issuer pushed without a credit");

endmodule

// ==== hdl/csr_bus_pkg.sv ====
`include "debug_consts.svh"

package csr_bus_pkg;

    // one csr access from the external master
    typedef struct packed {
        logic                   wr;
        logic [11:0]            addr;
        logic [`DBG_XLEN-1:0]   wdata;
    } csr_req_t;

    // rdata carries the old register value on a write
    typedef struct packed {
        logic                   err;
        logic [`DBG_XLEN-1:0]   rdata;
    } csr_rsp_t;

    // debug entry notice from the trap handler
    typedef struct packed {
        logic                       irq;
        debug_csr_pkg::trap_code_t  code;
        logic [`DBG_XLEN-1:0]       pc;
        debug_csr_pkg::priv_lvl_t   prv;
    } dbg_entry_t;

endpackage

// ==== hdl/debug_csr_pkg.sv ====
`include "debug_consts.svh"

package debug_csr_pkg;

    // privilege levels as reported by the trap handler
    typedef logic [1:0] priv_lvl_t;

    localparam priv_lvl_t PRV_U    = 2'b00;
    localparam priv_lvl_t PRV_S    = 2'b01;
    localparam priv_lvl_t PRV_RSVD = 2'b10;
    localparam priv_lvl_t PRV_M    = 2'b11;

    // dcsr layout, msb first
    typedef struct packed {
        logic [3:0]  xdebugver;
        logic [11:0] zero2;
        logic        ebreakm;
        logic        zero1;
        logic        ebreaks;
        logic        ebreaku;
        logic        stepie;
        logic        stopcount;
        logic        stoptime;
        logic [2:0]  cause;
        logic        zero0;
        logic        mprven;
        logic        nmip;
        logic        step;
        priv_lvl_t   prv;
    } dcsr_fields_t;

    // raw view for the bus, field view for warl and cause updates
    typedef union packed {
        dcsr_fields_t           fields;
        logic [`DBG_XLEN-1:0]   raw;
    } dcsr_word_u;

    typedef enum logic [2:0] {
        CAUSE_NONE    = 3'd0,
        CAUSE_EBREAK  = 3'd1,
        CAUSE_HALTREQ = 3'd3,
        CAUSE_STEP    = 3'd4
    } dbg_cause_e;

    // mcause exception / interrupt code
    typedef logic [3:0] trap_code_t;

    localparam trap_code_t BREAKPOINT  = 4'd3;
    localparam trap_code_t DEBUG_INT_M = 4'd14;

    localparam logic [11:0] CSR_DCSR      = 12'h7b0;
    localparam logic [11:0] CSR_DPC       = 12'h7b1;
    localparam logic [11:0] CSR_DSCRATCH0 = 12'h7b2;
    localparam logic [11:0] CSR_DSCRATCH1 = 12'h7b3;

endpackage

// ==== hdl/debug_consts.svh ====
`ifndef DEBUG_CONSTS_SVH
`define DEBUG_CONSTS_SVH

// csr data path width
`define DBG_XLEN 32

// request queue entries, also the issuer's starting credit count
`define DBG_FIFO_DEPTH 4

// credit and occupancy counters must hold the full depth
`define DBG_CREDIT_W 3

// debug spec version reported in dcsr.xdebugver
`define DBG_XDEBUGVER 4

`endif
